//--- Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := outbound_read_path_tb
RTL_TOP    := outbound_read_path
FILELIST   := outbound_read_path.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- outbound_read_path.f
rtl/pcie_rd_pkg.sv
rtl/outbound_read_req.sv
rtl/credit_fifo.sv
rtl/read_tlp_header_gen.sv
rtl/outbound_read_path.sv
tests/outbound_read_path_tb.sv

//--- rtl/credit_fifo.sv
module credit_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic empty,
    output logic credit_return
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count         <= count + CNT_W'(push) - CNT_W'(pop);
            credit_return <= pop;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (count != CNT_W'(DEPTH)))
        else $error("push into full queue");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("pop from empty queue");

endmodule

//--- rtl/outbound_read_path.sv
module outbound_read_path #(
    parameter int ADDR     = 32,
    parameter int LEN      = 4,
    parameter int MAX_SIZE = 512,
    parameter int DEPTH    = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ar_valid,
    output logic                     ar_ready,
    input  logic [ADDR-1:0]          ar_addr,
    input  logic [LEN-1:0]           ar_len,
    input  pcie_rd_pkg::mrr_e        max_read_request,
    output logic                     hdr_valid,
    input  logic                     hdr_ready,
    output pcie_rd_pkg::tlp_rd_hdr_t hdr
);
    import pcie_rd_pkg::*;

    logic      push;
    rd_split_t push_data;
    logic      credit_return;
    logic      empty;
    logic      pop;
    rd_split_t pop_data;

    outbound_read_req #(
        .ADDR     (ADDR),
        .LEN      (LEN),
        .MAX_SIZE (MAX_SIZE),
        .DEPTH    (DEPTH)
    ) u_req (
        .clk              (clk),
        .rst              (rst),
        .ar_valid         (ar_valid),
        .ar_ready         (ar_ready),
        .ar_addr          (ar_addr),
        .ar_len           (ar_len),
        .max_read_request (max_read_request),
        .credit_return    (credit_return),
        .push             (push),
        .push_data        (push_data)
    );

    credit_fifo #(
        .T     (rd_split_t),
        .DEPTH (DEPTH)
    ) u_fifo (
        .clk           (clk),
        .rst           (rst),
        .push          (push),
        .push_data     (push_data),
        .pop           (pop),
        .pop_data      (pop_data),
        .empty         (empty),
        .credit_return (credit_return)
    );

    read_tlp_header_gen u_hdr_gen (
        .clk       (clk),
        .rst       (rst),
        .empty     (empty),
        .pop_data  (pop_data),
        .pop       (pop),
        .hdr_ready (hdr_ready),
        .hdr_valid (hdr_valid),
        .hdr       (hdr)
    );

endmodule

//--- rtl/outbound_read_req.sv
module outbound_read_req #(
    parameter int ADDR     = 32,
    parameter int LEN      = 4,
    parameter int MAX_SIZE = 512,
    parameter int DEPTH    = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    input  logic [ADDR-1:0]        ar_addr,
    input  logic [LEN-1:0]         ar_len,
    input  pcie_rd_pkg::mrr_e      max_read_request,
    input  logic                   credit_return,
    output logic                   push,
    output pcie_rd_pkg::rd_split_t push_data
);
    import pcie_rd_pkg::*;

    localparam int CRED_W = $clog2(DEPTH + 1);
    localparam logic [10:0] MAX_SIZE_DW =
        (MAX_SIZE >= 4096) ? 11'd1024 : 11'(MAX_SIZE / 4);

    logic            cmd_present;
    logic [ADDR-1:2] cmd_addr;
    logic [11:2]     cmd_addr_last;
    logic [10:0]     cmd_len;
    logic [ADDR-1:2] next_cmd_addr;
    logic [11:2]     next_cmd_addr_last;
    logic [10:0]     next_cmd_len;
    logic            cmd_can_merge;
    logic            cmd_valid;
    logic            cmd_ready;

    logic [10:0]     max_len;

    logic            split_valid;
    logic [ADDR-1:2] split_addr;
    logic [10:0]     split_len;
    logic            split_last;
    logic [ADDR-1:2] next_split_addr;
    logic [10:0]     next_split_len;
    logic            next_split_last;
    logic            has_credit;

    logic [CRED_W-1:0] credits;

    // cmd_addr_last is the dword offset just past the held request
    always_comb begin
        if (!cmd_present) begin
            next_cmd_addr      = ar_addr[ADDR-1:2];
            next_cmd_addr_last = ar_addr[11:2] + 10'(ar_len) + 10'd1;
            next_cmd_len       = 11'(ar_len) + 11'd1;
        end else begin
            next_cmd_addr      = cmd_addr;
            next_cmd_addr_last = cmd_addr_last + 10'(ar_len) + 10'd1;
            next_cmd_len       = cmd_len + 11'(ar_len) + 11'd1;
        end
    end

    // End at offset 0 means the held request already reaches the page end
    assign cmd_can_merge = cmd_present && ar_valid &&
                           (ar_addr[ADDR-1:12] == cmd_addr[ADDR-1:12]) &&
                           (ar_addr[11:2] == cmd_addr_last) &&
                           (cmd_addr_last != '0);

    assign ar_ready  = !cmd_present || cmd_can_merge;
    assign cmd_valid = cmd_present && !cmd_can_merge;
    assign cmd_ready = !split_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_present <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                cmd_present <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                cmd_present <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            cmd_addr      <= next_cmd_addr;
            cmd_addr_last <= next_cmd_addr_last;
            cmd_len       <= next_cmd_len;
        end
    end

    // Piece size in dwords capped by what the bridge supports
    always_ff @(posedge clk) begin
        case (max_read_request)
            MRR_4096: max_len <= (MAX_SIZE_DW >= 11'd1024) ? 11'd1024 : MAX_SIZE_DW;
            MRR_2048: max_len <= (MAX_SIZE_DW >= 11'd512) ? 11'd512 : MAX_SIZE_DW;
            MRR_1024: max_len <= (MAX_SIZE_DW >= 11'd256) ? 11'd256 : MAX_SIZE_DW;
            MRR_512:  max_len <= (MAX_SIZE_DW >= 11'd128) ? 11'd128 : MAX_SIZE_DW;
            MRR_256:  max_len <= (MAX_SIZE_DW >= 11'd64) ? 11'd64 : MAX_SIZE_DW;
            default:  max_len <= (MAX_SIZE_DW >= 11'd32) ? 11'd32 : MAX_SIZE_DW;
        endcase
    end

    // Split stage walks the request inside its page
    always_comb begin
        if (!split_valid) begin
            next_split_addr = cmd_addr;
            next_split_len  = cmd_len;
            next_split_last = (cmd_len <= max_len);
        end else begin
            next_split_addr = {split_addr[ADDR-1:12], split_addr[11:2] + max_len[9:0]};
            next_split_len  = split_len - max_len;
            next_split_last = ({1'b0, split_len} <= {max_len, 1'b0});
        end
    end

    assign has_credit = (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            split_valid <= 1'b0;
        end else begin
            if (has_credit && split_last) begin
                split_valid <= 1'b0;
            end
            if (cmd_valid && cmd_ready) begin
                split_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!split_valid || has_credit) begin
            split_addr <= next_split_addr;
            split_len  <= next_split_len;
            split_last <= next_split_last;
        end
    end

    assign push           = split_valid && has_credit;
    assign push_data.addr = DW_ADDR_W'(split_addr);
    assign push_data.len  = split_last ? split_len : max_len;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(DEPTH);
        end else begin
            credits <= credits - CRED_W'(push) + CRED_W'(credit_return);
        end
    end

    a_credit_range: assert property (@(posedge clk) disable iff (rst)
        credits <= CRED_W'(DEPTH))
        else $error("credit count out of range");

    // A return with no push must find room below DEPTH
    a_credit_overflow: assert property (@(posedge clk) disable iff (rst)
        (credit_return && !push) |-> (credits < CRED_W'(DEPTH)))
        else $error("credit returned beyond queue depth");

endmodule

//--- rtl/pcie_rd_pkg.sv
package pcie_rd_pkg;

    // Dword address wide enough for a 64-bit byte address
    localparam int DW_ADDR_W = 62;
    localparam int TAG_W     = 8;

    // One request piece, len in dwords, 1024 is a full 4 KB page
    typedef struct packed {
        logic [DW_ADDR_W-1:0] addr;
        logic [10:0]          len;
    } rd_split_t;

    // Memory-read TLP header fields
    typedef struct packed {
        logic                 fmt_4dw;
        logic [TAG_W-1:0]     tag;
        logic [9:0]           len;
        logic [3:0]           first_be;
        logic [3:0]           last_be;
        logic [DW_ADDR_W-1:0] addr;
    } tlp_rd_hdr_t;

    // Max read request size, codes 6 and 7 fall back to 128 bytes
    typedef enum logic [2:0] {
        MRR_128  = 3'd0,
        MRR_256  = 3'd1,
        MRR_512  = 3'd2,
        MRR_1024 = 3'd3,
        MRR_2048 = 3'd4,
        MRR_4096 = 3'd5
    } mrr_e;

endpackage

//--- rtl/read_tlp_header_gen.sv
module read_tlp_header_gen (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     empty,
    input  pcie_rd_pkg::rd_split_t   pop_data,
    output logic                     pop,
    input  logic                     hdr_ready,
    output logic                     hdr_valid,
    output pcie_rd_pkg::tlp_rd_hdr_t hdr
);
    import pcie_rd_pkg::*;

    logic [TAG_W-1:0] tag_cnt;
    logic [TAG_W-1:0] next_tag;
    logic             hdr_done;

    assign hdr_done = hdr_valid && hdr_ready;
    assign pop      = !empty && (!hdr_valid || hdr_ready);

    // Tag the new header with the value it will hold at its own handshake
    assign next_tag = hdr_done ? tag_cnt + 1'b1 : tag_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_cnt   <= '0;
            hdr_valid <= 1'b0;
        end else begin
            tag_cnt <= next_tag;
            if (pop) begin
                hdr_valid <= 1'b1;
            end else if (hdr_ready) begin
                hdr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            // Byte address bits above 31 need the 4DW format
            hdr.fmt_4dw  <= (pop_data.addr[DW_ADDR_W-1:30] != '0);
            hdr.tag      <= next_tag;
            // 1024 dwords wraps to 0 in the 10-bit field
            hdr.len      <= pop_data.len[9:0];
            hdr.first_be <= 4'b1111;
            hdr.last_be  <= (pop_data.len == 11'd1) ? 4'b0000 : 4'b1111;
            hdr.addr     <= pop_data.addr;
        end
    end

    a_hdr_stable: assert property (@(posedge clk) disable iff (rst)
        (hdr_valid && !hdr_ready) |=> (hdr_valid && $stable(hdr)))
        else $error("header changed while stalled");

endmodule

//--- tests/outbound_read_path_tb.sv
module outbound_read_path_tb;
    import pcie_rd_pkg::*;

    localparam int ADDR     = 64;
    localparam int LEN      = 4;
    localparam int MAX_SIZE = 512;
    localparam int DEPTH    = 4;

    typedef struct packed {
        logic [7:0]  grp;
        logic [63:0] addr;
        logic [3:0]  len;
        logic [2:0]  mrr;
        logic        stall;
        logic [15:0] count;
        logic [15:0] stride;
    } row_t;

    // Group, byte address, AXI len, MRR code, random stalls, repeat count, byte stride
    localparam int NUM_ROWS = 21;
    localparam row_t ROWS [NUM_ROWS] = '{
        '{8'd0,  64'h0000_0000_0000_1000, 4'd3,  3'd2, 1'b0, 16'd1,   16'd0},
        '{8'd1,  64'h0000_0000_0000_2040, 4'd0,  3'd0, 1'b0, 16'd1,   16'd0},
        '{8'd2,  64'h0000_0000_0000_3000, 4'd15, 3'd2, 1'b0, 16'd2,   16'd64},
        '{8'd2,  64'h0000_0000_0000_3080, 4'd7,  3'd2, 1'b0, 16'd1,   16'd0},
        '{8'd2,  64'h0000_0000_0000_3400, 4'd3,  3'd2, 1'b0, 16'd1,   16'd0},
        '{8'd3,  64'h0000_0000_0000_4000, 4'd15, 3'd0, 1'b0, 16'd4,   16'd64},
        '{8'd3,  64'h0000_0000_0000_4100, 4'd7,  3'd0, 1'b0, 16'd1,   16'd0},
        '{8'd4,  64'h0000_0000_0000_5000, 4'd15, 3'd7, 1'b0, 16'd3,   16'd64},
        '{8'd5,  64'h0000_0000_0000_6000, 4'd15, 3'd5, 1'b1, 16'd9,   16'd64},
        '{8'd6,  64'h0000_0000_0000_6f80, 4'd15, 3'd2, 1'b0, 16'd2,   16'd64},
        '{8'd6,  64'h0000_0000_0000_7000, 4'd15, 3'd2, 1'b0, 16'd1,   16'd0},
        '{8'd6,  64'h0000_0000_0000_7fc0, 4'd15, 3'd2, 1'b0, 16'd1,   16'd0},
        '{8'd6,  64'h0000_0000_0000_7000, 4'd15, 3'd2, 1'b0, 16'd1,   16'd0},
        '{8'd7,  64'h0000_0001_0000_2000, 4'd1,  3'd1, 1'b0, 16'd1,   16'd0},
        '{8'd7,  64'h0000_0001_0000_2008, 4'd0,  3'd1, 1'b0, 16'd1,   16'd0},
        '{8'd7,  64'h0000_0002_0000_200c, 4'd0,  3'd1, 1'b0, 16'd1,   16'd0},
        '{8'd8,  64'h0000_0000_0000_8000, 4'd15, 3'd3, 1'b0, 16'd12,  16'd64},
        '{8'd9,  64'h0000_0000_0000_a000, 4'd15, 3'd4, 1'b1, 16'd9,   16'd64},
        '{8'd10, 64'h0000_0000_0000_c000, 4'd15, 3'd1, 1'b0, 16'd5,   16'd64},
        '{8'd11, 64'h0000_0000_0000_d000, 4'd15, 3'd6, 1'b1, 16'd3,   16'd64},
        '{8'd12, 64'h0000_0000_0010_0000, 4'd0,  3'd0, 1'b1, 16'd260, 16'd8}
    };

    logic            clk;
    logic            rst;
    logic            ar_valid;
    logic            ar_ready;
    logic [ADDR-1:0] ar_addr;
    logic [LEN-1:0]  ar_len;
    mrr_e            max_read_request;
    logic            hdr_valid;
    logic            hdr_ready;
    tlp_rd_hdr_t     hdr;

    tlp_rd_hdr_t      exp_q [$];
    tlp_rd_hdr_t      held_hdr;
    logic             held_valid = 1'b0;
    logic [TAG_W-1:0] exp_tag = '0;
    logic [31:0]      lfsr = 32'hdf6d_efda;
    logic             stall_mode = 1'b0;
    int               errors = 0;
    int               checks = 0;
    int               hdr_count = 0;
    int               cycles = 0;
    int               limit = 0;

    outbound_read_path #(
        .ADDR     (ADDR),
        .LEN      (LEN),
        .MAX_SIZE (MAX_SIZE),
        .DEPTH    (DEPTH)
    ) u_dut (
        .clk              (clk),
        .rst              (rst),
        .ar_valid         (ar_valid),
        .ar_ready         (ar_ready),
        .ar_addr          (ar_addr),
        .ar_len           (ar_len),
        .max_read_request (max_read_request),
        .hdr_valid        (hdr_valid),
        .hdr_ready        (hdr_ready),
        .hdr              (hdr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic int total_cmds();
        int n;
        int r;
        n = 0;
        for (r = 0; r < NUM_ROWS; r++) begin
            n = n + int'(ROWS[r].count);
        end
        return n;
    endfunction

    // Split one joined request into headers and queue them
    task automatic add_pieces(logic [61:0] addr, logic [10:0] len, logic [2:0] code);
        int          bytes;
        logic [10:0] max_len;
        logic [10:0] plen;
        logic [10:0] rem;
        logic [61:0] a;
        tlp_rd_hdr_t h;
        bytes = (code <= 3'd5) ? (128 << code) : 128;
        if (bytes > MAX_SIZE) begin
            bytes = MAX_SIZE;
        end
        max_len = 11'(bytes / 4);
        a       = addr;
        rem     = len;
        while (rem != 11'd0) begin
            plen       = (rem < max_len) ? rem : max_len;
            h.fmt_4dw  = (a[61:30] != '0);
            h.tag      = exp_tag;
            h.len      = plen[9:0];
            h.first_be = 4'hf;
            h.last_be  = (plen == 11'd1) ? 4'h0 : 4'hf;
            h.addr     = a;
            exp_q.push_back(h);
            exp_tag = exp_tag + 8'd1;
            a       = a + 62'(plen);
            rem     = rem - plen;
        end
    endtask

    // Merge rule applied to the commands of one group
    task automatic build_expected(int first, int last);
        int          r;
        int          k;
        logic        have;
        logic [61:0] a;
        logic [61:0] cur_addr;
        logic [61:0] cur_end;
        logic [10:0] cur_len;
        have     = 1'b0;
        cur_addr = '0;
        cur_len  = '0;
        for (r = first; r < last; r++) begin
            for (k = 0; k < int'(ROWS[r].count); k++) begin
                a = 62'((ROWS[r].addr + 64'(k) * 64'(ROWS[r].stride)) >> 2);
                cur_end = cur_addr + 62'(cur_len);
                if (have && a[61:10] == cur_addr[61:10] && a == cur_end &&
                    cur_end[9:0] != 10'd0) begin
                    cur_len = cur_len + 11'(ROWS[r].len) + 11'd1;
                end else begin
                    if (have) begin
                        add_pieces(cur_addr, cur_len, ROWS[first].mrr);
                    end
                    cur_addr = a;
                    cur_len  = 11'(ROWS[r].len) + 11'd1;
                    have     = 1'b1;
                end
            end
        end
        if (have) begin
            add_pieces(cur_addr, cur_len, ROWS[first].mrr);
        end
    endtask

    // Drives every command of a row with ar_valid held high between them
    task automatic send_row(int r);
        int   k;
        logic accepted;
        for (k = 0; k < int'(ROWS[r].count); k++) begin
            ar_valid = 1'b1;
            ar_addr  = ROWS[r].addr + 64'(k) * 64'(ROWS[r].stride);
            ar_len   = ROWS[r].len;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = ar_ready;
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic check_header();
        tlp_rd_hdr_t e;
        checks++;
        hdr_count++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("unexpected header at %0t with tag %0d, none was due", $time, hdr.tag);
        end else begin
            e = exp_q.pop_front();
            if (hdr != e) begin
                errors++;
                $display("mismatch at %0t: expected addr %h len %0d tag %0d be %h/%h fmt %b",
                         $time, e.addr, e.len, e.tag, e.first_be, e.last_be, e.fmt_4dw);
                $display("mismatch at %0t: got      addr %h len %0d tag %0d be %h/%h fmt %b",
                         $time, hdr.addr, hdr.len, hdr.tag, hdr.first_be, hdr.last_be,
                         hdr.fmt_4dw);
            end
        end
    endtask

    // Sampled mid-cycle where DUT outputs and driven inputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (held_valid && (!hdr_valid || hdr != held_hdr)) begin
                errors++;
                $display("mismatch at %0t: header changed or dropped while stalled", $time);
            end
            held_valid = hdr_valid && !hdr_ready;
            held_hdr   = hdr;
            if (hdr_valid && hdr_ready) begin
                check_header();
            end
        end
    end

    initial begin
        hdr_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            hdr_ready = stall_mode ? lfsr_bit() : 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int i;
        int j;
        int r;
        int grp_err;
        int grp_hdrs;
        int passed;
        int failed;
        passed           = 0;
        failed           = 0;
        limit            = 40 * total_cmds() + 200;
        rst              = 1'b1;
        ar_valid         = 1'b0;
        ar_addr          = '0;
        ar_len           = '0;
        max_read_request = MRR_128;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        i   = 0;
        while (i < NUM_ROWS) begin
            j = i;
            while (j < NUM_ROWS && ROWS[j].grp == ROWS[i].grp) begin
                j++;
            end
            grp_err          = errors;
            grp_hdrs         = hdr_count;
            max_read_request = mrr_e'(ROWS[i].mrr);
            stall_mode       = ROWS[i].stall;
            build_expected(i, j);
            // One idle cycle so max_len picks up the new code
            @(posedge clk);
            #1;
            for (r = i; r < j; r++) begin
                send_row(r);
            end
            ar_valid = 1'b0;
            while (exp_q.size() != 0) begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk);
            #1;
            if (errors == grp_err) begin
                passed++;
            end else begin
                failed++;
            end
            $display("group %0d: %0d headers, %0d errors", ROWS[i].grp,
                     hdr_count - grp_hdrs, errors - grp_err);
            i = j;
        end
        $display("tests %0d passed, %0d failed, %0d header checks, %0d errors",
                 passed, failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
